// ==== bench/issue_tb.sv ====
`timescale 1ns/1ps

module issue_tb
    import ooo_types_pkg::*;
    import ooo_cfg_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int N_RANDOM   = 30;
    // producer and consumer pairs
    localparam int N_CHAIN    = 12;
    localparam int N_AFTER    = 6;
    // random + chains + mask rounds + flush victims + after flush
    localparam int N_PLANNED  = N_RANDOM + 2 * N_CHAIN + NUM_CLASSES * NUM_CLASSES
                                + NUM_CLASSES + N_AFTER;
    localparam int CYCLES_PER_INSTR = 40;
    localparam int WATCHDOG_CYCLES  = N_PLANNED * CYCLES_PER_INSTR + 100;
    localparam int HOLD_LIMIT       = 200;
    localparam int IDLE_LIMIT       = 200;
    // never dispatched, so waiters on it stay asleep
    localparam rob_tag_t GHOST_TAG  = 5'd31;

    logic        clk;
    logic        rst_n;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        dispatch_valid;
    dispatch_t   dispatch;
    logic [2:0]  dispatch_ready;
    cdb_t        cdb;

    logic [31:0] lfsr_q;
    // scoreboard, written by the stimulus side
    word_t       exp_word [32];
    int          issued_n [32];
    bit          flushed [32];
    int          issued_total;
    int          flushed_total;
    int          count_base;
    int          next_tag;
    // written by the monitor only
    int          seen_n [32];
    int          broadcasts;

    issue_top #(
        .MUL_STAGES (3)
    ) UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .apb_req        (apb_req),
        .apb_rsp        (apb_rsp),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .cdb            (cdb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_run();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic fail_now(input string why);
        $display("ERROR: %s", why);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
            stop_run();
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit, msb first
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[31]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    function automatic op_class_t class_of(int i);
        case (i)
            0:       return CLASS_ALU;
            1:       return CLASS_MUL;
            default: return CLASS_BR;
        endcase
    endfunction

    // architectural result of one instruction
    function automatic word_t expected_result(op_class_t cls, alu_op_t aop, br_op_t bop,
                                              word_t a, word_t b);
        word_t r;
        r = '0;
        if (cls == CLASS_MUL) begin
            r = a * b;
        end else if (cls == CLASS_BR) begin
            case (bop)
                BR_EQ:   r = (a == b) ? 32'd1 : 32'd0;
                BR_NE:   r = (a != b) ? 32'd1 : 32'd0;
                BR_LT:   r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default: r = (a < b) ? 32'd1 : 32'd0;
            endcase
        end else begin
            case (aop)
                ALU_ADD: r = a + b;
                ALU_SUB: r = a - b;
                ALU_AND: r = a & b;
                ALU_OR:  r = a | b;
                ALU_XOR: r = a ^ b;
                ALU_SLL: r = a << b[4:0];
                ALU_SRL: r = a >> b[4:0];
                default: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            endcase
        end
        return r;
    endfunction

    // skip tags still in flight and flushed ones
    task automatic alloc_tag(output rob_tag_t t);
        int tries;
        tries = 0;
        while (issued_n[next_tag] != seen_n[next_tag] || flushed[next_tag]) begin
            next_tag = (next_tag + 1) % 31;
            tries++;
            if (tries > 31) fail_now("no free rob tag left to allocate");
        end
        t = next_tag[4:0];
        next_tag = (next_tag + 1) % 31;
    endtask

    task automatic make_instr(input op_class_t cls, output dispatch_t d, output word_t e);
        logic [31:0] v;
        rob_tag_t    t;
        d = '0;
        d.op_class = cls;
        draw_bits(3, v);
        d.alu_op = alu_op_t'(v[2:0]);
        draw_bits(2, v);
        d.br_op = br_op_t'(v[1:0]);
        draw_bits(32, v);
        d.src1 = '{ready: 1'b1, tag: 5'd0, value: v};
        draw_bits(32, v);
        d.src2 = '{ready: 1'b1, tag: 5'd0, value: v};
        // equal operands now and then, so beq and bne both go taken
        draw_bits(2, v);
        if (v[1:0] == 2'd0) d.src2.value = d.src1.value;
        alloc_tag(t);
        d.dest = t;
        e = expected_result(cls, d.alu_op, d.br_op, d.src1.value, d.src2.value);
    endtask

    // record then hold valid until the class slot takes it
    task automatic send_instr(input dispatch_t d, input word_t e);
        int waited;
        waited = 0;
        exp_word[d.dest] = e;
        issued_n[d.dest] = issued_n[d.dest] + 1;
        issued_total = issued_total + 1;
        @(posedge clk);
        dispatch_valid <= 1'b1;
        dispatch       <= d;
        @(negedge clk);
        while (!dispatch_ready[d.op_class]) begin
            waited++;
            if (waited > HOLD_LIMIT) fail_now("dispatch held too long, slot never freed");
            @(negedge clk);
        end
        @(posedge clk);
        dispatch_valid <= 1'b0;
    endtask

    // nothing outstanding and every slot empty
    task automatic wait_idle();
        int cycles;
        cycles = 0;
        @(negedge clk);
        #1;
        while ((issued_total - flushed_total - broadcasts) != 0 || dispatch_ready != 3'b111) begin
            cycles++;
            if (cycles > IDLE_LIMIT) fail_now("outstanding results were never broadcast");
            @(negedge clk);
            #1;
        end
    endtask

    task automatic write_reg(input apb_addr_t addr, input word_t data);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        // no wait states and no error on a mapped register
        check_value("apb_rsp.pready", 32'(apb_rsp.pready), 32'h1);
        check_value("apb_rsp.pslverr", 32'(apb_rsp.pslverr), 32'h0);
        // write lands at this edge
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic read_reg(input apb_addr_t addr, output word_t data);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        data = apb_rsp.prdata;
        check_value("apb_rsp.pready", 32'(apb_rsp.pready), 32'h1);
        check_value("apb_rsp.pslverr", 32'(apb_rsp.pslverr), 32'h0);
        @(posedge clk);
        apb_req <= '0;
    endtask

    // scoreboard check of every broadcast
    always @(negedge clk) begin
        if (rst_n && cdb.valid) begin
            if (flushed[cdb.tag]) begin
                fail_now($sformatf("flushed tag %0d appeared on the cdb", cdb.tag));
            end else if (issued_n[cdb.tag] == 0) begin
                fail_now($sformatf("tag %0d broadcast but never dispatched", cdb.tag));
            end else if (seen_n[cdb.tag] >= issued_n[cdb.tag]) begin
                fail_now($sformatf("duplicate broadcast of tag %0d", cdb.tag));
            end else begin
                check_value("cdb.data", cdb.data, exp_word[cdb.tag]);
                seen_n[cdb.tag] = seen_n[cdb.tag] + 1;
                broadcasts = broadcasts + 1;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_now("watchdog expired before the tests finished");
    end

    initial begin
        dispatch_t d;
        dispatch_t c;
        word_t     e;
        word_t     ce;
        word_t     v;
        logic [31:0] r;
        rob_tag_t  held [NUM_CLASSES];
        int        leftover;
        rst_n          = 1'b0;
        apb_req        = '0;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        lfsr_q         = 32'hfff2_642c;
        issued_total   = 0;
        flushed_total  = 0;
        broadcasts     = 0;
        count_base     = 0;
        next_tag       = 0;
        for (int t = 0; t < 32; t++) begin
            exp_word[t] = '0;
            issued_n[t] = 0;
            seen_n[t]   = 0;
            flushed[t]  = 1'b0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("dispatch_ready after reset", 32'(dispatch_ready), 32'h7);
        check_value("cdb.valid after reset", 32'(cdb.valid), 32'h0);
        write_reg(REG_CTRL, 32'h1);
        write_reg(REG_MASK, 32'h7);

        // independent mix, back-pressure from busy slots
        for (int i = 0; i < N_RANDOM; i++) begin
            draw_bits(2, r);
            make_instr(class_of(int'(r % 3)), d, e);
            send_instr(d, e);
        end

        // consumer in another class than its producer
        for (int i = 0; i < N_CHAIN; i++) begin
            wait_idle();
            draw_bits(2, r);
            make_instr(class_of(int'(r % 3)), d, e);
            draw_bits(1, r);
            make_instr(class_of((int'(d.op_class) + 1 + int'(r[0])) % 3), c, ce);
            // stale value left in the waiting operand
            draw_bits(1, r);
            if (r[0]) begin
                c.src1.ready = 1'b0;
                c.src1.tag   = d.dest;
                ce = expected_result(c.op_class, c.alu_op, c.br_op, e, c.src2.value);
            end else begin
                c.src2.ready = 1'b0;
                c.src2.tag   = d.dest;
                ce = expected_result(c.op_class, c.alu_op, c.br_op, c.src1.value, e);
            end
            // producer first hits the bypass for alu and br
            draw_bits(1, r);
            if (r[0]) begin
                send_instr(d, e);
                send_instr(c, ce);
            end else begin
                send_instr(c, ce);
                send_instr(d, e);
            end
        end

        // one class masked while the others keep going
        for (int k = 0; k < NUM_CLASSES; k++) begin
            wait_idle();
            write_reg(REG_MASK, 32'(3'b111 & ~(3'b001 << k)));
            make_instr(class_of(k), d, e);
            send_instr(d, e);
            for (int j = 0; j < NUM_CLASSES; j++) begin
                if (j != k) begin
                    make_instr(class_of(j), c, ce);
                    send_instr(c, ce);
                end
            end
            repeat (8) @(negedge clk);
            #1;
            check_value("dispatch_ready of masked class", 32'(dispatch_ready[k]), 32'h0);
            check_value("broadcasts of masked tag", seen_n[d.dest], issued_n[d.dest] - 1);
            write_reg(REG_MASK, 32'h7);
            wait_idle();
        end

        // count clear while idle
        write_reg(REG_COUNT, 32'h0);
        count_base = broadcasts;
        read_reg(REG_COUNT, v);
        check_value("REG_COUNT after clear", v, 32'h0);

        // every slot parked on a tag that never comes
        for (int k = 0; k < NUM_CLASSES; k++) begin
            make_instr(class_of(k), d, e);
            d.src1.ready = 1'b0;
            d.src1.tag   = GHOST_TAG;
            send_instr(d, e);
            held[k] = d.dest;
        end
        repeat (4) @(negedge clk);
        check_value("dispatch_ready before flush", 32'(dispatch_ready), 32'h0);
        // all three slots parked
        read_reg(REG_STATUS, v);
        check_value("REG_STATUS", v, 32'h7);
        // enable stays on, flush strobe set
        write_reg(REG_CTRL, 32'h3);
        repeat (2) @(negedge clk);
        check_value("dispatch_ready after flush", 32'(dispatch_ready), 32'h7);
        for (int k = 0; k < NUM_CLASSES; k++) begin
            flushed[held[k]] = 1'b1;
            flushed_total = flushed_total + 1;
        end
        read_reg(REG_CTRL, v);
        check_value("REG_CTRL after flush", v, 32'h1);
        read_reg(REG_STATUS, v);
        check_value("REG_STATUS after flush", v, 32'h0);

        for (int i = 0; i < N_AFTER; i++) begin
            draw_bits(2, r);
            make_instr(class_of(int'(r % 3)), d, e);
            send_instr(d, e);
        end
        wait_idle();
        read_reg(REG_COUNT, v);
        check_value("REG_COUNT", v, 32'(broadcasts - count_base));

        leftover = 0;
        for (int t = 0; t < 32; t++) begin
            if (!flushed[t] && issued_n[t] != seen_n[t]) leftover++;
        end
        if (leftover != 0) begin
            fail_now($sformatf("%0d dispatched tags were never broadcast", leftover));
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

// ==== logic/cdb_arbiter.sv ====
`timescale 1ns/1ps

module cdb_arbiter
    import ooo_types_pkg::*;
(
    input  cdb_t alu_res,
    input  cdb_t mul_res,
    input  cdb_t br_res,
    output logic alu_grant,
    output logic mul_grant,
    output logic br_grant,
    output cdb_t cdb
);

    // fixed order, mul first since it stalls the longest pipe
    assign mul_grant = mul_res.valid;
    assign alu_grant = alu_res.valid && !mul_res.valid;
    assign br_grant  = br_res.valid && !mul_res.valid && !alu_res.valid;

    // one winner at most, idle bus is all zero
    always_comb begin
        if (mul_grant) begin
            cdb = mul_res;
        end else if (alu_grant) begin
            cdb = alu_res;
        end else if (br_grant) begin
            cdb = br_res;
        end else begin
            cdb = '0;
        end
    end

endmodule

// ==== logic/int_exec_unit.sv ====
`timescale 1ns/1ps

module int_exec_unit
    import ooo_types_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   flush,
    input  issue_t alu_in,
    input  issue_t br_in,
    output logic   alu_ready,
    output logic   br_ready,
    output cdb_t   alu_res,
    output cdb_t   br_res,
    input  logic   alu_grant,
    input  logic   br_grant
);

    // lane index into the holding arrays
    localparam int LANE_ALU = 0;
    localparam int LANE_BR  = 1;

    word_t      alu_word;
    logic       br_taken;
    logic [1:0] in_vld;
    logic [1:0] grant;
    logic [1:0] lane_rdy;
    logic [1:0] hold_vld;
    rob_tag_t   in_tag [2];
    word_t      in_word [2];
    rob_tag_t   hold_tag [2];
    word_t      hold_word [2];

    always_comb begin
        case (alu_in.alu_op)
            ALU_ADD: alu_word = alu_in.op_a + alu_in.op_b;
            ALU_SUB: alu_word = alu_in.op_a - alu_in.op_b;
            ALU_AND: alu_word = alu_in.op_a & alu_in.op_b;
            ALU_OR:  alu_word = alu_in.op_a | alu_in.op_b;
            ALU_XOR: alu_word = alu_in.op_a ^ alu_in.op_b;
            // shift amount from the low five bits
            ALU_SLL: alu_word = alu_in.op_a << alu_in.op_b[4:0];
            ALU_SRL: alu_word = alu_in.op_a >> alu_in.op_b[4:0];
            default: alu_word = {31'b0, $signed(alu_in.op_a) < $signed(alu_in.op_b)};
        endcase
        case (br_in.br_op)
            BR_EQ:   br_taken = (br_in.op_a == br_in.op_b);
            BR_NE:   br_taken = (br_in.op_a != br_in.op_b);
            BR_LT:   br_taken = ($signed(br_in.op_a) < $signed(br_in.op_b));
            default: br_taken = (br_in.op_a < br_in.op_b);
        endcase
    end

    assign in_vld            = {br_in.valid, alu_in.valid};
    assign grant             = {br_grant, alu_grant};
    assign in_tag[LANE_ALU]  = alu_in.dest;
    assign in_tag[LANE_BR]   = br_in.dest;
    assign in_word[LANE_ALU] = alu_word;
    assign in_word[LANE_BR]  = {31'b0, br_taken};

    for (genvar k = 0; k < 2; k++) begin : g_lane
        // room when empty or leaving this cycle
        assign lane_rdy[k] = !hold_vld[k] || grant[k];

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                hold_vld[k] <= 1'b0;
            end else if (flush) begin
                hold_vld[k] <= 1'b0;
            end else if (lane_rdy[k]) begin
                hold_vld[k] <= in_vld[k];
            end
        end

        always_ff @(posedge clk) begin
            if (lane_rdy[k] && in_vld[k]) begin
                hold_tag[k]  <= in_tag[k];
                hold_word[k] <= in_word[k];
            end
        end
    end

    assign alu_ready = lane_rdy[LANE_ALU];
    assign br_ready  = lane_rdy[LANE_BR];
    assign alu_res   = '{valid: hold_vld[LANE_ALU], tag: hold_tag[LANE_ALU],
                         data: hold_word[LANE_ALU]};
    assign br_res    = '{valid: hold_vld[LANE_BR], tag: hold_tag[LANE_BR],
                         data: hold_word[LANE_BR]};

endmodule

// ==== logic/issue_cfg_regs.sv ====
`timescale 1ns/1ps

module issue_cfg_regs
    import ooo_types_pkg::*;
    import ooo_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  apb_req_t   apb_req,
    output apb_rsp_t   apb_rsp,
    input  logic       cdb_valid,
    input  logic [2:0] occupied,
    output cfg_t       cfg
);

    logic       access;
    logic       wr_en;
    logic       issue_en;
    logic [2:0] mask_q;
    logic       flush_q;
    word_t      count_q;

    // access phase, no wait states
    assign access = apb_req.psel && apb_req.penable;
    assign wr_en  = access && apb_req.pwrite;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue_en <= 1'b0;
            mask_q   <= '0;
            flush_q  <= 1'b0;
            count_q  <= '0;
        end else begin
            // one-cycle strobe, stations clear on the next edge
            flush_q <= wr_en && (apb_req.paddr == REG_CTRL) && apb_req.pwdata[1];
            if (wr_en && (apb_req.paddr == REG_CTRL)) begin
                issue_en <= apb_req.pwdata[0];
            end
            if (wr_en && (apb_req.paddr == REG_MASK)) begin
                mask_q <= apb_req.pwdata[2:0];
            end
            // a clearing write beats a broadcast in the same cycle
            if (wr_en && (apb_req.paddr == REG_COUNT)) begin
                count_q <= '0;
            end else if (cdb_valid) begin
                count_q <= count_q + 32'd1;
            end
        end
    end

    always_comb begin
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = 1'b0;
        case (apb_req.paddr)
            // flush bit never reads back
            REG_CTRL:   apb_rsp.prdata = {31'b0, issue_en};
            REG_MASK:   apb_rsp.prdata = {29'b0, mask_q};
            REG_COUNT:  apb_rsp.prdata = count_q;
            REG_STATUS: apb_rsp.prdata = {29'b0, occupied};
            default: begin
                apb_rsp.prdata  = '0;
                apb_rsp.pslverr = access;
            end
        endcase
    end

    assign cfg.issue_mask = issue_en ? mask_q : 3'b000;
    assign cfg.flush      = flush_q;

endmodule

// ==== logic/issue_station.sv ====
`timescale 1ns/1ps

module issue_station
    import ooo_types_pkg::*;
    import ooo_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  cfg_t       cfg,
    input  logic       dispatch_valid,
    input  dispatch_t  dispatch,
    output logic [2:0] dispatch_ready,
    input  cdb_t       cdb,
    input  logic [2:0] lane_ready,
    output issue_t     issue [NUM_CLASSES],
    output logic [2:0] occupied
);

    // slot payload, class is implied by the slot index
    typedef struct packed {
        alu_op_t  alu_op;
        br_op_t   br_op;
        rob_tag_t dest;
        operand_t src1;
        operand_t src2;
    } slot_t;

    logic [2:0] slot_vld;
    slot_t      slot_q [NUM_CLASSES];
    logic [2:0] accept;
    logic [2:0] complete;
    logic [2:0] fire;

    // pick up a broadcast word when the operand waits on that tag
    function automatic operand_t wake(operand_t op, cdb_t bus);
        operand_t res;
        res = op;
        if (!op.ready && bus.valid && (bus.tag == op.tag)) begin
            res.ready = 1'b1;
            res.value = bus.data;
        end
        return res;
    endfunction

    // empty slot means ready, taken from registered state only
    assign dispatch_ready = ~slot_vld;
    assign occupied       = slot_vld;

    always_comb begin
        for (int i = 0; i < NUM_CLASSES; i++) begin
            // accept only into the slot of the instruction's class
            accept[i] = dispatch_valid && dispatch_ready[i] &&
                        (dispatch.op_class == op_class_t'(i));
            complete[i] = slot_vld[i] && slot_q[i].src1.ready && slot_q[i].src2.ready;
            // presented to the lane
            issue[i].valid  = complete[i] && cfg.issue_mask[i];
            issue[i].alu_op = slot_q[i].alu_op;
            issue[i].br_op  = slot_q[i].br_op;
            issue[i].dest   = slot_q[i].dest;
            issue[i].op_a   = slot_q[i].src1.value;
            issue[i].op_b   = slot_q[i].src2.value;
            // taken by the lane this edge
            fire[i] = issue[i].valid && lane_ready[i];
        end
    end

    // occupancy per slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_vld <= '0;
        end else if (cfg.flush) begin
            // flush drops everything, including a dispatch this cycle
            slot_vld <= '0;
        end else begin
            for (int i = 0; i < NUM_CLASSES; i++) begin
                if (accept[i]) begin
                    slot_vld[i] <= 1'b1;
                end else if (fire[i]) begin
                    slot_vld[i] <= 1'b0;
                end
            end
        end
    end

    // operand capture and wakeup
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_CLASSES; i++) begin
            if (accept[i]) begin
                // dispatch-cycle bypass from the cdb
                slot_q[i].alu_op <= dispatch.alu_op;
                slot_q[i].br_op  <= dispatch.br_op;
                slot_q[i].dest   <= dispatch.dest;
                slot_q[i].src1   <= wake(dispatch.src1, cdb);
                slot_q[i].src2   <= wake(dispatch.src2, cdb);
            end else begin
                // harmless on an empty or issuing slot
                slot_q[i].src1 <= wake(slot_q[i].src1, cdb);
                slot_q[i].src2 <= wake(slot_q[i].src2, cdb);
            end
        end
    end

endmodule

// ==== logic/issue_top.sv ====
`timescale 1ns/1ps

module issue_top
    import ooo_types_pkg::*;
    import ooo_cfg_pkg::*;
#(
    parameter int MUL_STAGES = 3
)(
    input  logic       clk,
    input  logic       rst_n,
    input  apb_req_t   apb_req,
    output apb_rsp_t   apb_rsp,
    input  logic       dispatch_valid,
    input  dispatch_t  dispatch,
    output logic [2:0] dispatch_ready,
    output cdb_t       cdb
);

    cfg_t       cfg;
    issue_t     issue [NUM_CLASSES];
    // bit order follows the class encoding
    logic [2:0] lane_ready;
    logic [2:0] occupied;
    cdb_t       alu_res;
    cdb_t       mul_res;
    cdb_t       br_res;
    logic       alu_grant;
    logic       mul_grant;
    logic       br_grant;

    issue_station u_station (
        .clk            (clk),
        .rst_n          (rst_n),
        .cfg            (cfg),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        // result bus doubles as wakeup
        .cdb            (cdb),
        .lane_ready     (lane_ready),
        .issue          (issue),
        .occupied       (occupied)
    );

    int_exec_unit u_int (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (cfg.flush),
        .alu_in    (issue[CLASS_ALU]),
        .br_in     (issue[CLASS_BR]),
        .alu_ready (lane_ready[CLASS_ALU]),
        .br_ready  (lane_ready[CLASS_BR]),
        .alu_res   (alu_res),
        .br_res    (br_res),
        .alu_grant (alu_grant),
        .br_grant  (br_grant)
    );

    mul_unit #(
        .MUL_STAGES (MUL_STAGES)
    ) u_mul (
        .clk       (clk),
        .rst_n     (rst_n),
        .flush     (cfg.flush),
        .mul_in    (issue[CLASS_MUL]),
        .mul_ready (lane_ready[CLASS_MUL]),
        .mul_res   (mul_res),
        .mul_grant (mul_grant)
    );

    cdb_arbiter u_arb (
        .alu_res   (alu_res),
        .mul_res   (mul_res),
        .br_res    (br_res),
        .alu_grant (alu_grant),
        .mul_grant (mul_grant),
        .br_grant  (br_grant),
        .cdb       (cdb)
    );

    issue_cfg_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .cdb_valid (cdb.valid),
        .occupied  (occupied),
        .cfg       (cfg)
    );

endmodule

// ==== logic/mul_unit.sv ====
`timescale 1ns/1ps

module mul_unit
    import ooo_types_pkg::*;
#(
    parameter int MUL_STAGES = 3
)(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   flush,
    input  issue_t mul_in,
    output logic   mul_ready,
    output cdb_t   mul_res,
    input  logic   mul_grant
);

    logic [MUL_STAGES-1:0] stg_vld;
    rob_tag_t              stg_tag [MUL_STAGES];
    // stage 0 keeps the low partial, later stages the full low word
    word_t                 stg_word [MUL_STAGES];
    // upper partial, only its low half reaches the low word
    logic [15:0]           hi_part;
    logic                  advance;

    // whole pipe moves only when the last stage can drain
    assign advance   = !stg_vld[MUL_STAGES-1] || mul_grant;
    assign mul_ready = advance;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stg_vld <= '0;
        end else if (flush) begin
            stg_vld <= '0;
        end else if (advance) begin
            stg_vld <= {stg_vld[MUL_STAGES-2:0], mul_in.valid};
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            // split b into halves, a*b_hi only matters mod 2^16
            stg_tag[0]  <= mul_in.dest;
            stg_word[0] <= mul_in.op_a * {16'b0, mul_in.op_b[15:0]};
            hi_part     <= mul_in.op_a[15:0] * mul_in.op_b[31:16];
            // recombine the partials
            stg_tag[1]  <= stg_tag[0];
            stg_word[1] <= stg_word[0] + {hi_part, 16'b0};
            for (int s = 2; s < MUL_STAGES; s++) begin
                stg_tag[s]  <= stg_tag[s-1];
                stg_word[s] <= stg_word[s-1];
            end
        end
    end

    assign mul_res = '{valid: stg_vld[MUL_STAGES-1], tag: stg_tag[MUL_STAGES-1],
                       data: stg_word[MUL_STAGES-1]};

endmodule

// ==== logic/ooo_cfg_pkg.sv ====
package ooo_cfg_pkg;

    // byte offset inside the register block
    typedef logic [7:0] apb_addr_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        apb_addr_t   paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
        logic        pslverr;
    } apb_rsp_t;

    // bit 0 issue enable, bit 1 flush strobe
    parameter apb_addr_t REG_CTRL   = 8'h00;
    // per class issue enable, alu mul br
    parameter apb_addr_t REG_MASK   = 8'h04;
    // broadcast count, write clears
    parameter apb_addr_t REG_COUNT  = 8'h08;
    // occupied slots
    parameter apb_addr_t REG_STATUS = 8'h0C;

    // mask already and-ed with the global enable
    typedef struct packed {
        logic [2:0] issue_mask;
        logic       flush;
    } cfg_t;

endpackage

// ==== logic/ooo_types_pkg.sv ====
package ooo_types_pkg;

    // one slot and one lane per class
    parameter int NUM_CLASSES = 3;

    // plain data word
    typedef logic [31:0] word_t;

    // rob index naming the producer of a value
    typedef logic [4:0] rob_tag_t;

    // class encoding doubles as slot and lane index
    typedef enum logic [1:0] {
        CLASS_ALU = 2'd0,
        CLASS_MUL = 2'd1,
        CLASS_BR  = 2'd2
    } op_class_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SLT
    } alu_op_t;

    // result word is 1 when taken
    typedef enum logic [1:0] {
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_LTU
    } br_op_t;

    // either a value (ready) or the tag it waits on
    typedef struct packed {
        logic     ready;
        rob_tag_t tag;
        word_t    value;
    } operand_t;

    // decoded instruction at the dispatch port
    typedef struct packed {
        op_class_t op_class;
        alu_op_t   alu_op;
        br_op_t    br_op;
        rob_tag_t  dest;
        operand_t  src1;
        operand_t  src2;
    } dispatch_t;

    // slot to lane, operands resolved
    typedef struct packed {
        logic     valid;
        alu_op_t  alu_op;
        br_op_t   br_op;
        rob_tag_t dest;
        word_t    op_a;
        word_t    op_b;
    } issue_t;

    // one broadcast result, also a lane result
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    data;
    } cdb_t;

endpackage

// ==== run.sh ====
#!/usr/bin/env bash
# build with verilator, run, and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --top-module issue_tb -f tb.f -o issue_sim > build.log 2>&1 \
    && ./obj_dir/issue_sim > sim.log 2>&1
[ -s sim.log ] && cat sim.log || { cat build.log; echo "no simulation log"; exit 1; }
grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0

// ==== tb.f ====
logic/ooo_types_pkg.sv
logic/ooo_cfg_pkg.sv
logic/issue_station.sv
logic/int_exec_unit.sv
logic/mul_unit.sv
logic/cdb_arbiter.sv
logic/issue_cfg_regs.sv
logic/issue_top.sv
bench/issue_tb.sv
